// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define CORE_XLEN	64
`define CORE_RADDR_W	6
`define CORE_NREGS	(1 << `CORE_RADDR_W)
`define CORE_INSN_W	32
`define CORE_IMM_W	16
`define CORE_OP_W	4

// instruction word fields, imm overlaps rs2 and rs3
`define CORE_OP_LSB	28
`define CORE_RD_LSB	22
`define CORE_RS1_LSB	16
`define CORE_RS2_LSB	10
`define CORE_RS3_LSB	4

`endif

// ==== rtl/core_pkg.sv ====
`default_nettype none

`include "core_settings.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0] xlen_t;
	typedef logic [`CORE_RADDR_W-1:0] reg_addr_t;
	typedef logic [`CORE_INSN_W-1:0] insn_t;
	typedef logic [`CORE_IMM_W-1:0] imm_t;
	typedef logic [1:0] lvt_tag_t;	// bank holding the newest copy

	typedef enum logic [`CORE_OP_W-1:0] {
		op_nop = 0,
		op_add = 1,
		op_sub = 2,
		op_and = 3,
		op_or = 4,
		op_xor = 5,
		op_sll = 6,
		op_srl = 7,
		op_sel = 8,	// c != 0 ? a : b
		op_addi = 9,
		op_li = 10	// codes above this decode as nop
	} alu_op_t;

	typedef struct packed {
		alu_op_t op;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rs3;
		xlen_t imm;	// already sign-extended
	} dec_lane_t;

	typedef struct packed {
		logic [2:0] valid;
		insn_t [2:0] insn;
	} issue_bundle_t;

	typedef struct packed {
		logic valid;
		reg_addr_t rd;
		xlen_t value;
	} wb_lane_t;

	typedef struct packed {
		wb_lane_t [2:0] lane;	// lane 2 in the top bits
	} wb_bundle_t;

endpackage

`default_nettype wire

// ==== rtl/issue_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module issue_decoder (
	input wire logic valid,
	input wire core_pkg::insn_t insn,
	output core_pkg::dec_lane_t dec
);

	logic [`CORE_OP_W-1:0] op_field;
	core_pkg::alu_op_t op;
	core_pkg::imm_t raw_imm;
	logic use_rs1;
	logic use_rs2;
	logic use_rs3;

	assign op_field = insn[`CORE_OP_LSB +: `CORE_OP_W];
	assign raw_imm = insn[`CORE_IMM_W-1:0];

	always_comb
	begin
		if (valid && op_field <= core_pkg::op_li)
			op = core_pkg::alu_op_t'(op_field);
		else
			op = core_pkg::op_nop;	// bubble or unknown code
	end

	always_comb
	begin
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_rs3 = 1'b0;
		case (op)
			core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and, core_pkg::op_or,
			core_pkg::op_xor, core_pkg::op_sll, core_pkg::op_srl:
			begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			core_pkg::op_sel:
			begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				use_rs3 = 1'b1;
			end
			core_pkg::op_addi:
				use_rs1 = 1'b1;
			default:
				;
		endcase
	end

	always_comb
	begin
		dec = '0;	// unused sources read r0
		dec.op = op;
		dec.imm = {{(`CORE_XLEN-`CORE_IMM_W){raw_imm[`CORE_IMM_W-1]}}, raw_imm};
		if (op != core_pkg::op_nop)
			dec.rd = insn[`CORE_RD_LSB +: `CORE_RADDR_W];
		if (use_rs1)
			dec.rs1 = insn[`CORE_RS1_LSB +: `CORE_RADDR_W];
		if (use_rs2)
			dec.rs2 = insn[`CORE_RS2_LSB +: `CORE_RADDR_W];
		if (use_rs3)
			dec.rs3 = insn[`CORE_RS3_LSB +: `CORE_RADDR_W];
	end

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module regfile (
	input wire logic wclk,
	input wire core_pkg::reg_addr_t wa0,
	input wire core_pkg::reg_addr_t wa1,
	input wire core_pkg::reg_addr_t wa2,
	input wire core_pkg::xlen_t i0,
	input wire core_pkg::xlen_t i1,
	input wire core_pkg::xlen_t i2,
	input wire core_pkg::reg_addr_t ra0,
	input wire core_pkg::reg_addr_t ra1,
	input wire core_pkg::reg_addr_t ra2,
	input wire core_pkg::reg_addr_t ra3,
	input wire core_pkg::reg_addr_t ra4,
	input wire core_pkg::reg_addr_t ra5,
	input wire core_pkg::reg_addr_t ra6,
	input wire core_pkg::reg_addr_t ra7,
	input wire core_pkg::reg_addr_t ra8,
	output core_pkg::xlen_t o0,
	output core_pkg::xlen_t o1,
	output core_pkg::xlen_t o2,
	output core_pkg::xlen_t o3,
	output core_pkg::xlen_t o4,
	output core_pkg::xlen_t o5,
	output core_pkg::xlen_t o6,
	output core_pkg::xlen_t o7,
	output core_pkg::xlen_t o8
);

	// one bank per write port
	core_pkg::xlen_t bank0 [`CORE_NREGS];
	core_pkg::xlen_t bank1 [`CORE_NREGS];
	core_pkg::xlen_t bank2 [`CORE_NREGS];
	core_pkg::lvt_tag_t lvt [`CORE_NREGS];

	always_ff @(posedge wclk)
	begin
		bank0[wa0] <= i0;
		bank1[wa1] <= i1;
		bank2[wa2] <= i2;
	end

	// later updates override earlier ones, so port 2 beats 1 beats 0
	always_ff @(posedge wclk)
	begin
		lvt[wa0] <= 2'd0;
		lvt[wa1] <= 2'd1;
		lvt[wa2] <= 2'd2;
	end

	function automatic core_pkg::xlen_t read_port(input core_pkg::reg_addr_t ra);
		core_pkg::xlen_t v;
		if (ra == '0)
			v = '0;
		else if (ra == wa2)
			v = i2;	// same-cycle write bypass
		else if (ra == wa1)
			v = i1;
		else if (ra == wa0)
			v = i0;
		else
		begin
			case (lvt[ra])
				2'd0: v = bank0[ra];
				2'd1: v = bank1[ra];
				default: v = bank2[ra];
			endcase
		end
		return v;
	endfunction

	always_comb
	begin
		o0 = read_port(ra0);
		o1 = read_port(ra1);
		o2 = read_port(ra2);
		o3 = read_port(ra3);
		o4 = read_port(ra4);
		o5 = read_port(ra5);
		o6 = read_port(ra6);
		o7 = read_port(ra7);
		o8 = read_port(ra8);
	end

endmodule

`default_nettype wire

// ==== rtl/lane_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module lane_alu (
	input wire core_pkg::dec_lane_t dec,
	input wire core_pkg::xlen_t a,
	input wire core_pkg::xlen_t b,
	input wire core_pkg::xlen_t c,
	output core_pkg::xlen_t result
);

	logic [$clog2(`CORE_XLEN)-1:0] shamt;

	assign shamt = b[$clog2(`CORE_XLEN)-1:0];	// low bits of second operand

	always_comb
	begin
		case (dec.op)
			core_pkg::op_add:
				result = a + b;
			core_pkg::op_sub:
				result = a - b;
			core_pkg::op_and:
				result = a & b;
			core_pkg::op_or:
				result = a | b;
			core_pkg::op_xor:
				result = a ^ b;
			core_pkg::op_sll:
				result = a << shamt;
			core_pkg::op_srl:
				result = a >> shamt;	// logical, zero fill
			core_pkg::op_sel:
				result = (c != '0) ? a : b;
			core_pkg::op_addi:
				result = a + dec.imm;
			core_pkg::op_li:
				result = dec.imm;
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
	input wire logic wclk,
	input wire logic rst,
	input wire core_pkg::reg_addr_t rd0,
	input wire core_pkg::reg_addr_t rd1,
	input wire core_pkg::reg_addr_t rd2,
	input wire core_pkg::xlen_t res0,
	input wire core_pkg::xlen_t res1,
	input wire core_pkg::xlen_t res2,
	output core_pkg::reg_addr_t wa0,
	output core_pkg::reg_addr_t wa1,
	output core_pkg::reg_addr_t wa2,
	output core_pkg::xlen_t wd0,
	output core_pkg::xlen_t wd1,
	output core_pkg::xlen_t wd2,
	output core_pkg::wb_bundle_t wb
);

	core_pkg::reg_addr_t [2:0] rd_q;
	core_pkg::xlen_t [2:0] res_q;

	always_ff @(posedge wclk)
	begin
		if (rst)
		begin
			rd_q <= '0;	// all write ports aim at r0
		end
		else
		begin
			rd_q <= {rd2, rd1, rd0};
		end
	end

	always_ff @(posedge wclk)
	begin
		res_q <= {res2, res1, res0};
	end

	assign wa0 = rd_q[0];
	assign wa1 = rd_q[1];
	assign wa2 = rd_q[2];
	assign wd0 = res_q[0];
	assign wd1 = res_q[1];
	assign wd2 = res_q[2];

	always_comb
	begin
		for (int i = 0; i < 3; i++)
		begin
			wb.lane[i].valid = (rd_q[i] != '0);
			wb.lane[i].rd = rd_q[i];
			wb.lane[i].value = res_q[i];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tri_issue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tri_issue_core (
	input wire logic wclk,
	input wire logic rst,
	input wire core_pkg::issue_bundle_t issue,
	output core_pkg::wb_bundle_t wb
);

	core_pkg::dec_lane_t dec [3];
	core_pkg::xlen_t opnd [9];	// lane i uses 3i .. 3i+2
	core_pkg::xlen_t res [3];
	core_pkg::reg_addr_t wa0;
	core_pkg::reg_addr_t wa1;
	core_pkg::reg_addr_t wa2;
	core_pkg::xlen_t wd0;
	core_pkg::xlen_t wd1;
	core_pkg::xlen_t wd2;

	for (genvar i = 0; i < 3; i++)
	begin : g_lane
		issue_decoder u_dec (
			.valid(issue.valid[i]),
			.insn(issue.insn[i]),
			.dec(dec[i])
		);

		lane_alu u_alu (
			.dec(dec[i]),
			.a(opnd[3*i]),
			.b(opnd[3*i+1]),
			.c(opnd[3*i+2]),
			.result(res[i])
		);
	end

	regfile u_rf (
		.wclk(wclk),
		.wa0(wa0),
		.wa1(wa1),
		.wa2(wa2),
		.i0(wd0),
		.i1(wd1),
		.i2(wd2),
		.ra0(dec[0].rs1),
		.ra1(dec[0].rs2),
		.ra2(dec[0].rs3),
		.ra3(dec[1].rs1),
		.ra4(dec[1].rs2),
		.ra5(dec[1].rs3),
		.ra6(dec[2].rs1),
		.ra7(dec[2].rs2),
		.ra8(dec[2].rs3),
		.o0(opnd[0]),
		.o1(opnd[1]),
		.o2(opnd[2]),
		.o3(opnd[3]),
		.o4(opnd[4]),
		.o5(opnd[5]),
		.o6(opnd[6]),
		.o7(opnd[7]),
		.o8(opnd[8])
	);

	// results land in the register file one cycle after issue
	writeback_stage u_wb (
		.wclk(wclk),
		.rst(rst),
		.rd0(dec[0].rd),
		.rd1(dec[1].rd),
		.rd2(dec[2].rd),
		.res0(res[0]),
		.res1(res[1]),
		.res2(res[2]),
		.wa0(wa0),
		.wa1(wa1),
		.wa2(wa2),
		.wd0(wd0),
		.wd1(wd1),
		.wd2(wd2),
		.wb(wb)
	);

endmodule

`default_nettype wire

// ==== sim/tb_tri_issue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tb_tri_issue_core;

	localparam int RESET_CYCLES = 3;
	localparam int TABLE_ROWS = 15;
	localparam int LOAD_BUNDLES = 21;	// 63 registers, three per bundle
	localparam int RAND_BUNDLES = 200;
	localparam int WATCHDOG_NS = 2 * (TABLE_ROWS + LOAD_BUNDLES + RAND_BUNDLES + RESET_CYCLES) * 10;

	logic wclk;
	logic rst;
	core_pkg::issue_bundle_t issue;
	core_pkg::wb_bundle_t wb;

	core_pkg::issue_bundle_t stim_q [$];
	core_pkg::wb_bundle_t exp_q [$];
	core_pkg::xlen_t shadow [`CORE_NREGS];	// architectural register model

	tri_issue_core DUT (
		.wclk(wclk),
		.rst(rst),
		.issue(issue),
		.wb(wb)
	);

	initial
	begin
		wclk = 1'b0;
		forever #5 wclk = ~wclk;
	end

	initial
	begin
		#(WATCHDOG_NS * 1ns);
		$display("Timeout: the DUT did not finish the test sequence in time");
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [63:0] xorshift(input logic [63:0] s);
		logic [63:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	function automatic core_pkg::insn_t rrr_insn(input core_pkg::alu_op_t op, input int rd,
		input int rs1, input int rs2, input int rs3);
		return {op, rd[5:0], rs1[5:0], rs2[5:0], rs3[5:0], 4'b0000};
	endfunction

	function automatic core_pkg::insn_t imm_insn(input core_pkg::alu_op_t op, input int rd,
		input int rs1, input logic [15:0] imm);
		return {op, rd[5:0], rs1[5:0], imm};
	endfunction

	function automatic core_pkg::wb_lane_t wb_exp(input int rd, input core_pkg::xlen_t value);
		core_pkg::wb_lane_t e;
		e.valid = (rd != 0);
		e.rd = rd[5:0];
		e.value = value;
		return e;
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("ERR %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
			$display("Testbench failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_bundle(input core_pkg::wb_bundle_t got,
		input core_pkg::wb_bundle_t want, input string phase, input int r);
		int l;
		for (l = 0; l < 3; l++)
		begin
			check_value(got.lane[l].valid, want.lane[l].valid,
				$sformatf("%s row %0d lane %0d valid", phase, r, l));
			check_value(got.lane[l].rd, want.lane[l].rd,
				$sformatf("%s row %0d lane %0d rd", phase, r, l));
			if (want.lane[l].valid)
				check_value(got.lane[l].value, want.lane[l].value,
					$sformatf("%s row %0d lane %0d value", phase, r, l));
		end
	endtask

	task automatic add_row(input logic [2:0] mask, input core_pkg::insn_t i0,
		input core_pkg::insn_t i1, input core_pkg::insn_t i2, input core_pkg::wb_lane_t e0,
		input core_pkg::wb_lane_t e1, input core_pkg::wb_lane_t e2);
		core_pkg::issue_bundle_t bun;
		core_pkg::wb_bundle_t want;
		bun.valid = mask;
		bun.insn = {i2, i1, i0};
		want.lane = {e2, e1, e0};
		stim_q.push_back(bun);
		exp_q.push_back(want);
	endtask

	task automatic build_table();
		add_row(3'b000, '0, '0, '0, wb_exp(0, 0), wb_exp(0, 0), wb_exp(0, 0));
		add_row(3'b111, imm_insn(core_pkg::op_li, 1, 0, 16'h1234),
			imm_insn(core_pkg::op_li, 2, 0, 16'hfff0),
			imm_insn(core_pkg::op_li, 3, 0, 16'h7fff),
			wb_exp(1, 64'h1234), wb_exp(2, 64'hfffffffffffffff0), wb_exp(3, 64'h7fff));
		add_row(3'b111, imm_insn(core_pkg::op_addi, 4, 1, 16'h0010),	// reads row above by bypass
			imm_insn(core_pkg::op_addi, 5, 2, 16'h8000),
			imm_insn(core_pkg::op_li, 0, 0, 16'h0055),
			wb_exp(4, 64'h1244), wb_exp(5, 64'hffffffffffff7ff0), wb_exp(0, 0));
		add_row(3'b111, imm_insn(core_pkg::op_li, 6, 0, 16'h0003),
			imm_insn(core_pkg::op_li, 7, 0, 16'h00f0),
			imm_insn(core_pkg::op_li, 8, 0, 16'h0000),
			wb_exp(6, 64'h3), wb_exp(7, 64'hf0), wb_exp(8, 64'h0));
		add_row(3'b111, rrr_insn(core_pkg::op_add, 9, 1, 3, 0),
			rrr_insn(core_pkg::op_sub, 10, 1, 3, 0),
			rrr_insn(core_pkg::op_and, 11, 2, 7, 0),
			wb_exp(9, 64'h9233), wb_exp(10, 64'hffffffffffff9235), wb_exp(11, 64'hf0));
		add_row(3'b111, rrr_insn(core_pkg::op_or, 12, 1, 7, 0),
			rrr_insn(core_pkg::op_xor, 13, 1, 3, 0),
			rrr_insn(core_pkg::op_sll, 14, 1, 6, 0),
			wb_exp(12, 64'h12f4), wb_exp(13, 64'h6dcb), wb_exp(14, 64'h91a0));
		add_row(3'b111, rrr_insn(core_pkg::op_srl, 15, 2, 6, 0),
			rrr_insn(core_pkg::op_sel, 16, 3, 1, 6),
			rrr_insn(core_pkg::op_sel, 17, 3, 1, 8),
			wb_exp(15, 64'h1ffffffffffffffe), wb_exp(16, 64'h7fff), wb_exp(17, 64'h1234));
		add_row(3'b111, rrr_insn(core_pkg::op_add, 18, 0, 7, 0),	// r0 reads as zero
			rrr_insn(core_pkg::op_sub, 19, 0, 6, 0),
			rrr_insn(core_pkg::op_sel, 20, 1, 3, 0),
			wb_exp(18, 64'hf0), wb_exp(19, 64'hfffffffffffffffd), wb_exp(20, 64'h7fff));
		add_row(3'b011, rrr_insn(core_pkg::op_sll, 21, 1, 7, 0),	// shift by 48
			rrr_insn(core_pkg::op_srl, 22, 2, 5, 0),
			imm_insn(core_pkg::op_li, 23, 0, 16'h0099),
			wb_exp(21, 64'h1234000000000000), wb_exp(22, 64'hffff), wb_exp(0, 0));
		add_row(3'b111, imm_insn(core_pkg::op_li, 24, 0, 16'h0011),
			imm_insn(core_pkg::op_li, 25, 0, 16'h0022),
			imm_insn(core_pkg::op_li, 26, 0, 16'h0033),
			wb_exp(24, 64'h11), wb_exp(25, 64'h22), wb_exp(26, 64'h33));
		add_row(3'b111, imm_insn(core_pkg::op_li, 24, 0, 16'h0aaa),
			imm_insn(core_pkg::op_addi, 24, 24, 16'h0001),	// lane 1 wins r24
			imm_insn(core_pkg::op_addi, 25, 24, 16'h0002),
			wb_exp(24, 64'haaa), wb_exp(24, 64'h12), wb_exp(25, 64'h13));
		add_row(3'b111, imm_insn(core_pkg::op_li, 26, 0, 16'h0100),
			imm_insn(core_pkg::op_li, 26, 0, 16'h0200),
			imm_insn(core_pkg::op_li, 26, 0, 16'h0300),
			wb_exp(26, 64'h100), wb_exp(26, 64'h200), wb_exp(26, 64'h300));
		add_row(3'b111, rrr_insn(core_pkg::op_add, 27, 24, 0, 0),
			rrr_insn(core_pkg::op_add, 28, 26, 0, 0),
			rrr_insn(core_pkg::op_or, 29, 26, 24, 0),
			wb_exp(27, 64'h12), wb_exp(28, 64'h300), wb_exp(29, 64'h312));
		add_row(3'b111, rrr_insn(core_pkg::op_add, 30, 26, 25, 0),
			rrr_insn(core_pkg::op_xor, 31, 24, 24, 0),
			rrr_insn(core_pkg::op_sub, 32, 26, 24, 0),
			wb_exp(30, 64'h313), wb_exp(31, 64'h0), wb_exp(32, 64'h2ee));
		add_row(3'b001, 32'hf840_0000, imm_insn(core_pkg::op_li, 34, 0, 16'h0001), '0,
			wb_exp(0, 0), wb_exp(0, 0), wb_exp(0, 0));	// opcode 15 toward r33
	endtask

	// whole bundle reads the old state, then lanes 0, 1, 2 write in turn
	task automatic predict(input core_pkg::issue_bundle_t bun, output core_pkg::wb_bundle_t want);
		core_pkg::insn_t insn;
		logic [3:0] opc;
		core_pkg::reg_addr_t rd;
		core_pkg::xlen_t a;
		core_pkg::xlen_t b;
		core_pkg::xlen_t c;
		core_pkg::xlen_t imm;
		core_pkg::xlen_t val;
		int l;
		for (l = 0; l < 3; l++)
		begin
			insn = bun.insn[l];
			opc = insn[31:28];
			if (!bun.valid[l] || opc > 4'd10)
				opc = 4'd0;
			rd = (opc == 4'd0) ? '0 : insn[27:22];
			a = shadow[insn[21:16]];
			b = shadow[insn[15:10]];
			c = shadow[insn[9:4]];
			imm = {{(`CORE_XLEN-`CORE_IMM_W){insn[15]}}, insn[15:0]};
			case (opc)
				core_pkg::op_add: val = a + b;
				core_pkg::op_sub: val = a - b;
				core_pkg::op_and: val = a & b;
				core_pkg::op_or: val = a | b;
				core_pkg::op_xor: val = a ^ b;
				core_pkg::op_sll: val = a << b[5:0];
				core_pkg::op_srl: val = a >> b[5:0];
				core_pkg::op_sel: val = (c != 0) ? a : b;
				core_pkg::op_addi: val = a + imm;
				core_pkg::op_li: val = imm;
				default: val = '0;
			endcase
			want.lane[l].valid = (rd != 0);
			want.lane[l].rd = rd;
			want.lane[l].value = val;
		end
		for (l = 0; l < 3; l++)
		begin
			if (want.lane[l].valid)
				shadow[want.lane[l].rd] = want.lane[l].value;
		end
	endtask

	task automatic build_random();
		logic [63:0] rng;
		core_pkg::issue_bundle_t bun;
		core_pkg::wb_bundle_t want;
		int n;
		int l;
		rng = 64'd48183;
		for (n = 0; n < `CORE_NREGS; n++)
			shadow[n] = '0;
		for (n = 0; n < LOAD_BUNDLES; n++)
		begin
			bun.valid = 3'b111;
			for (l = 0; l < 3; l++)
			begin
				rng = xorshift(rng);
				bun.insn[l] = imm_insn(core_pkg::op_li, 3*n + l + 1, 0, rng[15:0]);
			end
			predict(bun, want);
			stim_q.push_back(bun);
			exp_q.push_back(want);
		end
		for (n = 0; n < RAND_BUNDLES; n++)
		begin
			for (l = 0; l < 3; l++)
			begin
				rng = xorshift(rng);
				bun.valid[l] = (rng[63:62] != 2'b00);
				bun.insn[l] = rng[31:0];
				if (l > 0 && rng[45:44] == 2'b00)
					bun.insn[l][27:22] = bun.insn[l-1][27:22];	// force a collision
			end
			predict(bun, want);
			stim_q.push_back(bun);
			exp_q.push_back(want);
		end
	endtask

	// bundle r goes in after one edge, its results are on wb after the next
	task automatic apply_rows(input string phase);
		int r;
		for (r = 0; r <= stim_q.size(); r++)
		begin
			@(posedge wclk);
			if (r < stim_q.size())
				issue <= stim_q[r];
			else
				issue <= '0;
			@(negedge wclk);
			if (r > 0)
				check_bundle(wb, exp_q[r-1], phase, r-1);
		end
	endtask

	initial
	begin
		rst = 1'b1;
		issue.valid = 3'b111;	// live bundle under reset must not reach wb
		issue.insn = {imm_insn(core_pkg::op_li, 3, 0, 16'h0333),
			imm_insn(core_pkg::op_li, 2, 0, 16'h0222),
			imm_insn(core_pkg::op_li, 1, 0, 16'h0111)};
		build_table();
		check_value(stim_q.size(), TABLE_ROWS, "directed table length");
		repeat (RESET_CYCLES) @(posedge wclk);
		rst <= 1'b0;
		issue <= '0;
		@(negedge wclk);
		check_bundle(wb, '0, "reset", 0);
		apply_rows("table");
		stim_q.delete();
		exp_q.delete();
		build_random();
		apply_rows("random");
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
rtl/core_pkg.sv
rtl/issue_decoder.sv
rtl/regfile.sv
rtl/lane_alu.sv
rtl/writeback_stage.sv
rtl/tri_issue_core.sv
sim/tb_tri_issue_core.sv
